//--- files.f
rtl/exec_pkg.sv
rtl/ldst_if.sv
rtl/exec_arith.sv
rtl/exec_shift.sv
rtl/exec_logic.sv
rtl/exec_branch.sv
rtl/data_ram.sv
rtl/execute_stage.sv
rtl/exec_top.sv
test/exec_tb.sv

//--- rtl/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input logic clk,
    input logic reset,
    ldst_if.mem bus
);

    logic [exec_pkg::W_OPR-1:0] ram [0:255];
    logic [exec_pkg::W_OPR-1:0] rdata_r;
    logic [7:0]                 index;

    assign index = bus.addr[9:2]; // Word index.

    // Unwritten words read as zero.
    initial begin
        for (int i = 0; i < 256; i++) begin
            ram[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (bus.write) begin
            ram[index] <= bus.wdata;
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            rdata_r <= '0;
        end else if (bus.read_en) begin
            rdata_r <= ram[index];
        end
    end

    assign bus.rdata = rdata_r;

endmodule

//--- rtl/exec_arith.sv
`timescale 1ns/1ps

module exec_arith (
    input  logic [exec_pkg::W_OPR-1:0]    opr0_i,
    input  logic [exec_pkg::W_OPR-1:0]    opr1_i,
    input  logic [exec_pkg::W_SELECT-1:0] select_i,
    input  logic                          carry_i,
    output logic [exec_pkg::W_OPR-1:0]    result_o,
    output logic [exec_pkg::W_FLAGS-1:0]  flags_o
);

    logic                       sub;
    logic                       cin;
    logic [exec_pkg::W_OPR-1:0] opr_b;
    logic [exec_pkg::W_OPR:0]   sum;

    always_comb begin
        sub = 1'b0;
        cin = 1'b0;
        case (select_i)
            exec_pkg::ADD: cin = 1'b0;
            exec_pkg::ADC: cin = carry_i;
            exec_pkg::SUB, exec_pkg::CMP: begin
                sub = 1'b1;
                cin = 1'b1;
            end
            exec_pkg::SBC: begin
                sub = 1'b1;
                cin = carry_i; // Carry set means no borrow.
            end
            default: cin = 1'b0;
        endcase
    end

    // Subtraction as a plus inverted b plus carry in.
    assign opr_b = sub ? ~opr1_i : opr1_i;
    assign sum = {1'b0, opr0_i} + {1'b0, opr_b} + {{exec_pkg::W_OPR{1'b0}}, cin};

    assign result_o = (select_i == exec_pkg::CMP) ? '0 : sum[exec_pkg::W_OPR-1:0];

    always_comb begin
        flags_o = '0;
        flags_o[exec_pkg::FLAG_C] = sum[exec_pkg::W_OPR]; // Inverted borrow on subtract.
        flags_o[exec_pkg::FLAG_Z] = (sum[exec_pkg::W_OPR-1:0] == '0);
        flags_o[exec_pkg::FLAG_S] = sum[exec_pkg::W_OPR-1];
        flags_o[exec_pkg::FLAG_V] = (opr0_i[exec_pkg::W_OPR-1] == opr_b[exec_pkg::W_OPR-1])
                                  & (sum[exec_pkg::W_OPR-1] != opr0_i[exec_pkg::W_OPR-1]);
    end

endmodule

//--- rtl/exec_branch.sv
`timescale 1ns/1ps

module exec_branch (
    input  logic                          valid_i,
    input  logic [exec_pkg::W_CC-1:0]     cc_i,
    input  logic [exec_pkg::W_FLAGS-1:0]  flags_i,
    input  logic [exec_pkg::ADDR-1:0]     pc_i,
    input  logic [exec_pkg::ADDR-1:0]     target_i,
    input  logic [exec_pkg::W_SELECT-1:0] select_i,
    output logic                          branch_o,
    output logic [exec_pkg::ADDR-1:0]     branch_addr_o
);

    logic c, z, s, v;
    logic taken;

    assign c = flags_i[exec_pkg::FLAG_C];
    assign z = flags_i[exec_pkg::FLAG_Z];
    assign s = flags_i[exec_pkg::FLAG_S];
    assign v = flags_i[exec_pkg::FLAG_V];

    always_comb begin
        case (cc_i)
            exec_pkg::CC_AL: taken = 1'b1;
            exec_pkg::CC_EQ: taken = z;
            exec_pkg::CC_NE: taken = ~z;
            exec_pkg::CC_CS: taken = c;
            exec_pkg::CC_CC: taken = ~c;
            exec_pkg::CC_MI: taken = s;
            exec_pkg::CC_PL: taken = ~s;
            exec_pkg::CC_VS: taken = v;
            exec_pkg::CC_LT: taken = s ^ v;
            exec_pkg::CC_GE: taken = ~(s ^ v);
            default:         taken = 1'b0;
        endcase
    end

    assign branch_o = valid_i & taken;

    // Select bit 0 set means pc relative, clear means absolute.
    assign branch_addr_o = select_i[0] ? pc_i + target_i : target_i;

endmodule

//--- rtl/exec_logic.sv
`timescale 1ns/1ps

module exec_logic (
    input  logic [exec_pkg::W_OPR-1:0]    opr0_i,
    input  logic [exec_pkg::W_OPR-1:0]    opr1_i,
    input  logic [exec_pkg::W_IMM-1:0]    imm_i,
    input  logic [exec_pkg::W_SELECT-1:0] select_i,
    output logic [exec_pkg::W_OPR-1:0]    result_o,
    output logic [exec_pkg::W_FLAGS-1:0]  flags_o
);

    always_comb begin
        case (select_i)
            exec_pkg::AND:  result_o = opr0_i & opr1_i;
            exec_pkg::OR:   result_o = opr0_i | opr1_i;
            exec_pkg::XOR:  result_o = opr0_i ^ opr1_i;
            exec_pkg::NAND: result_o = ~(opr0_i & opr1_i);
            // Immediate to high half, low half cleared.
            exec_pkg::SETH: result_o = {imm_i, {(exec_pkg::W_OPR - exec_pkg::W_IMM){1'b0}}};
            default:        result_o = '0;
        endcase
    end

    always_comb begin
        flags_o = '0; // Carry and overflow clear.
        flags_o[exec_pkg::FLAG_Z] = (result_o == '0);
        flags_o[exec_pkg::FLAG_S] = result_o[exec_pkg::W_OPR-1];
    end

endmodule

//--- rtl/exec_pkg.sv
package exec_pkg;

    localparam int W_OPR    = 32;
    localparam int W_IMM    = 16;
    localparam int ADDR     = 16;
    localparam int W_RD     = 5;
    localparam int W_FLAGS  = 4;
    localparam int W_CC     = 4;
    localparam int W_EXEC   = 4;
    localparam int W_SELECT = 4;

    // Flag bit positions.
    localparam int FLAG_C = 0;
    localparam int FLAG_Z = 1;
    localparam int FLAG_S = 2;
    localparam int FLAG_V = 3;

    localparam logic [W_EXEC-1:0] EX_ARITH = 4'd0;
    localparam logic [W_EXEC-1:0] EX_SHIFT = 4'd1;
    localparam logic [W_EXEC-1:0] EX_LOGIC = 4'd2;
    localparam logic [W_EXEC-1:0] EX_NONE  = 4'd15; // No result, flags kept.

    localparam logic [W_SELECT-1:0] ADD = 4'd0;
    localparam logic [W_SELECT-1:0] ADC = 4'd1;
    localparam logic [W_SELECT-1:0] SUB = 4'd2;
    localparam logic [W_SELECT-1:0] SBC = 4'd3;
    localparam logic [W_SELECT-1:0] CMP = 4'd4;

    localparam logic [W_SELECT-1:0] SLL = 4'd0;
    localparam logic [W_SELECT-1:0] SRL = 4'd1;
    localparam logic [W_SELECT-1:0] SRA = 4'd2;
    localparam logic [W_SELECT-1:0] ROR = 4'd3;

    localparam logic [W_SELECT-1:0] AND  = 4'd0;
    localparam logic [W_SELECT-1:0] OR   = 4'd1;
    localparam logic [W_SELECT-1:0] XOR  = 4'd2;
    localparam logic [W_SELECT-1:0] NAND = 4'd3;
    localparam logic [W_SELECT-1:0] SETH = 4'd4;

    localparam logic [W_CC-1:0] CC_AL = 4'd0;
    localparam logic [W_CC-1:0] CC_EQ = 4'd1;
    localparam logic [W_CC-1:0] CC_NE = 4'd2;
    localparam logic [W_CC-1:0] CC_CS = 4'd3;
    localparam logic [W_CC-1:0] CC_CC = 4'd4;
    localparam logic [W_CC-1:0] CC_MI = 4'd5;
    localparam logic [W_CC-1:0] CC_PL = 4'd6;
    localparam logic [W_CC-1:0] CC_VS = 4'd7;
    localparam logic [W_CC-1:0] CC_LT = 4'd8; // Sign differs from overflow.
    localparam logic [W_CC-1:0] CC_GE = 4'd9;

    // Decoded control word, executor in the top bits.
    typedef struct packed {
        logic [W_EXEC-1:0]   executor;
        logic [W_SELECT-1:0] select;
        logic                immf;
        logic                sign;
        logic                lstf;  // Select bit 0 set means store.
        logic                brf;
        logic                hltf;
        logic                wrsv;
        logic [1:0]          spare;
    } dec_info_t;

endpackage

//--- rtl/exec_shift.sv
`timescale 1ns/1ps

module exec_shift (
    input  logic [exec_pkg::W_OPR-1:0]          opr0_i,
    input  logic [$clog2(exec_pkg::W_OPR)-1:0] amount_i,
    input  logic [exec_pkg::W_SELECT-1:0]       select_i,
    output logic [exec_pkg::W_OPR-1:0]          result_o,
    output logic [exec_pkg::W_FLAGS-1:0]        flags_o
);

    logic [exec_pkg::W_OPR:0] wide; // One extra bit catches the last bit out.
    logic                     carry;

    always_comb begin
        wide     = '0;
        carry    = 1'b0;
        result_o = '0;
        case (select_i)
            exec_pkg::SLL: begin
                wide     = {1'b0, opr0_i} << amount_i;
                result_o = wide[exec_pkg::W_OPR-1:0];
                carry    = wide[exec_pkg::W_OPR];
            end
            exec_pkg::SRL: begin
                wide     = {opr0_i, 1'b0} >> amount_i;
                result_o = wide[exec_pkg::W_OPR:1];
                carry    = wide[0];
            end
            exec_pkg::SRA: begin
                wide     = $signed({opr0_i, 1'b0}) >>> amount_i;
                result_o = wide[exec_pkg::W_OPR:1];
                carry    = wide[0];
            end
            exec_pkg::ROR: begin
                result_o = (opr0_i >> amount_i) | (opr0_i << (exec_pkg::W_OPR - amount_i));
                carry    = (amount_i != '0) & result_o[exec_pkg::W_OPR-1];
            end
            default: result_o = '0;
        endcase
    end

    always_comb begin
        flags_o = '0; // Overflow stays clear.
        flags_o[exec_pkg::FLAG_C] = carry;
        flags_o[exec_pkg::FLAG_Z] = (result_o == '0);
        flags_o[exec_pkg::FLAG_S] = result_o[exec_pkg::W_OPR-1];
    end

endmodule

//--- rtl/exec_top.sv
`timescale 1ns/1ps

module exec_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       v_i,
    input  logic                       stall_i,
    input  logic [exec_pkg::ADDR-1:0]  pc_i,
    input  logic [exec_pkg::W_IMM-1:0] imm_i,
    input  logic [exec_pkg::W_OPR-1:0] opr0_i,
    input  logic [exec_pkg::W_OPR-1:0] opr1_i,
    input  exec_pkg::dec_info_t        d_info_i,
    input  logic [exec_pkg::W_RD-1:0]  wb_r_i,
    output logic                       v_o,
    output logic                       stall_o,
    output logic [exec_pkg::W_OPR-1:0] result_o,
    output logic [exec_pkg::W_RD-1:0]  wb_r_o,
    output logic                       wb_o,
    output logic                       branch_o,
    output logic [exec_pkg::ADDR-1:0]  branch_addr_o,
    output logic                       hlt_o,
    output logic                       brf_o
);

    ldst_if bus_i ();

    execute_stage stage_i (
        .clk(clk), .reset(reset),
        .v_i(v_i), .v_o(v_o),
        .stall_i(stall_i), .stall_o(stall_o),
        .pc_i(pc_i), .imm_i(imm_i),
        .opr0_i(opr0_i), .opr1_i(opr1_i),
        .d_info_i(d_info_i), .wb_r_i(wb_r_i),
        .result_o(result_o), .wb_r_o(wb_r_o), .wb_o(wb_o),
        .branch_o(branch_o), .branch_addr_o(branch_addr_o),
        .hlt_o(hlt_o), .brf_o(brf_o),
        .mem(bus_i.stage)
    );

    data_ram ram_i (
        .clk(clk),
        .reset(reset),
        .bus(bus_i.mem)
    );

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       v_i,
    output logic                       v_o,
    input  logic                       stall_i,
    output logic                       stall_o,
    input  logic [exec_pkg::ADDR-1:0]  pc_i,
    input  logic [exec_pkg::W_IMM-1:0] imm_i,
    input  logic [exec_pkg::W_OPR-1:0] opr0_i,
    input  logic [exec_pkg::W_OPR-1:0] opr1_i,
    input  exec_pkg::dec_info_t        d_info_i,
    input  logic [exec_pkg::W_RD-1:0]  wb_r_i,
    output logic [exec_pkg::W_OPR-1:0] result_o,
    output logic [exec_pkg::W_RD-1:0]  wb_r_o,
    output logic                       wb_o,
    output logic                       branch_o,
    output logic [exec_pkg::ADDR-1:0]  branch_addr_o,
    output logic                       hlt_o,
    output logic                       brf_o,
    ldst_if.stage                      mem
);

    localparam int W_EXT = exec_pkg::W_OPR - exec_pkg::W_IMM;

    logic                          advance;
    logic [exec_pkg::W_OPR-1:0]    imm_ext;
    logic [exec_pkg::W_OPR-1:0]    opr_b;
    logic [exec_pkg::W_OPR-1:0]    arith_res, shift_res, logic_res, sel_res;
    logic [exec_pkg::W_FLAGS-1:0]  arith_flags, shift_flags, logic_flags, sel_flags;
    logic                          v_r, wbf_r, ld_r;
    logic [exec_pkg::W_FLAGS-1:0]  flags_r;
    logic [exec_pkg::W_OPR-1:0]    result_r;
    logic [exec_pkg::W_RD-1:0]     rd_r;

    assign advance = ~stall_i | ~v_r;

    assign imm_ext = d_info_i.sign ? {{W_EXT{imm_i[exec_pkg::W_IMM-1]}}, imm_i}
                                   : {{W_EXT{1'b0}}, imm_i};
    assign opr_b = d_info_i.immf ? imm_ext : opr1_i;

    exec_arith arith_i (
        .opr0_i(opr0_i), .opr1_i(opr_b), .select_i(d_info_i.select),
        .carry_i(flags_r[exec_pkg::FLAG_C]), .result_o(arith_res), .flags_o(arith_flags)
    );

    exec_shift shift_i (
        .opr0_i(opr0_i), .amount_i(opr_b[$clog2(exec_pkg::W_OPR)-1:0]),
        .select_i(d_info_i.select), .result_o(shift_res), .flags_o(shift_flags)
    );

    exec_logic logic_i (
        .opr0_i(opr0_i), .opr1_i(opr_b), .imm_i(imm_i), .select_i(d_info_i.select),
        .result_o(logic_res), .flags_o(logic_flags)
    );

    // Flags seen here belong to the previous instruction.
    exec_branch branch_i (
        .valid_i(brf_o), .cc_i(opr0_i[exec_pkg::W_CC-1:0]), .flags_i(flags_r),
        .pc_i(pc_i), .target_i(opr_b[exec_pkg::ADDR-1:0]), .select_i(d_info_i.select),
        .branch_o(branch_o), .branch_addr_o(branch_addr_o)
    );

    always_comb begin
        sel_res   = '0;
        sel_flags = flags_r;
        case (d_info_i.executor)
            exec_pkg::EX_ARITH: begin
                sel_res   = arith_res;
                sel_flags = arith_flags;
            end
            exec_pkg::EX_SHIFT: begin
                sel_res   = shift_res;
                sel_flags = shift_flags;
            end
            exec_pkg::EX_LOGIC: begin
                sel_res   = logic_res;
                sel_flags = logic_flags;
            end
            exec_pkg::EX_NONE: sel_flags = flags_r;
            default:           sel_flags = flags_r;
        endcase
    end

    // Memory access, store only on the accepting edge.
    assign mem.addr    = opr0_i[exec_pkg::ADDR-1:0] + imm_ext[exec_pkg::ADDR-1:0];
    assign mem.wdata   = opr1_i;
    assign mem.write   = v_i & d_info_i.lstf & d_info_i.select[0] & advance;
    assign mem.read_en = advance;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            v_r     <= 1'b0;
            wbf_r   <= 1'b0;
            ld_r    <= 1'b0;
            flags_r <= '0;
        end else if (advance) begin
            v_r   <= v_i;
            wbf_r <= d_info_i.wrsv;
            ld_r  <= d_info_i.lstf & ~d_info_i.select[0];
            if (v_i) begin
                flags_r <= sel_flags;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            result_r <= sel_res;
            rd_r     <= wb_r_i;
        end
    end

    assign v_o      = v_r;
    assign stall_o  = stall_i;
    assign result_o = ld_r ? mem.rdata : result_r; // Load word from read register.
    assign wb_r_o   = rd_r;
    assign wb_o     = v_r & wbf_r;
    assign hlt_o    = v_i & d_info_i.hltf;
    assign brf_o    = v_i & d_info_i.brf;

endmodule

//--- rtl/ldst_if.sv
`timescale 1ns/1ps

interface ldst_if;

    logic [exec_pkg::ADDR-1:0]  addr;
    logic                       write;   // One-cycle store strobe.
    logic [exec_pkg::W_OPR-1:0] wdata;
    logic                       read_en; // High whenever the stage advances.
    logic [exec_pkg::W_OPR-1:0] rdata;

    modport stage (
        output addr, write, wdata, read_en,
        input  rdata
    );

    modport mem (
        input  addr, write, wdata, read_en,
        output rdata
    );

endinterface

//--- test/exec_tb.sv
`timescale 1ns/1ps

module exec_tb;

    typedef struct packed {
        exec_pkg::dec_info_t        d;
        logic [exec_pkg::W_OPR-1:0] a;
        logic [exec_pkg::W_OPR-1:0] b;
        logic [exec_pkg::W_IMM-1:0] imm;
        logic [exec_pkg::ADDR-1:0]  pc;
        logic [exec_pkg::W_RD-1:0]  rd;
        logic                       chk_res;
        logic [exec_pkg::W_OPR-1:0] res;
        logic                       br;
        logic [exec_pkg::ADDR-1:0]  baddr;
        logic [7:0]                 stall;   // Cycles of stall_i while this row sits on v_o.
    } row_t;

    logic                       clk;
    logic                       reset;
    logic                       v_i;
    logic                       stall_i;
    logic [exec_pkg::ADDR-1:0]  pc_i;
    logic [exec_pkg::W_IMM-1:0] imm_i;
    logic [exec_pkg::W_OPR-1:0] opr0_i;
    logic [exec_pkg::W_OPR-1:0] opr1_i;
    exec_pkg::dec_info_t        d_info_i;
    logic [exec_pkg::W_RD-1:0]  wb_r_i;
    logic                       v_o;
    logic                       stall_o;
    logic [exec_pkg::W_OPR-1:0] result_o;
    logic [exec_pkg::W_RD-1:0]  wb_r_o;
    logic                       wb_o;
    logic                       branch_o;
    logic [exec_pkg::ADDR-1:0]  branch_addr_o;
    logic                       hlt_o;
    logic                       brf_o;

    row_t rows [0:63];
    int   n_rows;
    int   total_stall;
    logic table_done;

    exec_top dut_i (
        .clk(clk), .reset(reset), .v_i(v_i), .stall_i(stall_i),
        .pc_i(pc_i), .imm_i(imm_i), .opr0_i(opr0_i), .opr1_i(opr1_i),
        .d_info_i(d_info_i), .wb_r_i(wb_r_i),
        .v_o(v_o), .stall_o(stall_o), .result_o(result_o), .wb_r_o(wb_r_o), .wb_o(wb_o),
        .branch_o(branch_o), .branch_addr_o(branch_addr_o), .hlt_o(hlt_o), .brf_o(brf_o)
    );

    always #50 clk = ~clk;

    // Flag bits in order immf, sign, lstf, brf, hltf, wrsv.
    function automatic exec_pkg::dec_info_t make_info(
        input logic [exec_pkg::W_EXEC-1:0]   unit,
        input logic [exec_pkg::W_SELECT-1:0] sel,
        input logic [5:0]                    bits
    );
        exec_pkg::dec_info_t d;
        d.executor = unit;
        d.select   = sel;
        {d.immf, d.sign, d.lstf, d.brf, d.hltf, d.wrsv} = bits;
        d.spare    = 2'b00;
        return d;
    endfunction

    function automatic logic [exec_pkg::W_OPR-1:0] rotate_right(
        input logic [exec_pkg::W_OPR-1:0] a,
        input logic [4:0]                 n
    );
        logic [2*exec_pkg::W_OPR-1:0] both;
        both = {a, a} >> n;
        return both[exec_pkg::W_OPR-1:0];
    endfunction

    task automatic add_row(
        input exec_pkg::dec_info_t        d,
        input logic [exec_pkg::W_OPR-1:0] a,
        input logic [exec_pkg::W_OPR-1:0] b,
        input logic [exec_pkg::W_IMM-1:0] imm,
        input logic [exec_pkg::ADDR-1:0]  pc,
        input logic [exec_pkg::W_RD-1:0]  rd,
        input logic                       chk_res,
        input logic [exec_pkg::W_OPR-1:0] res,
        input logic                       br,
        input logic [exec_pkg::ADDR-1:0]  baddr,
        input int                         stall
    );
        rows[n_rows] = '{d, a, b, imm, pc, rd, chk_res, res, br, baddr, stall[7:0]};
        n_rows      = n_rows + 1;
        total_stall = total_stall + stall;
    endtask

    task automatic build_table;
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] rc;
        logic [31:0] rs;
        logic [4:0]  n;
        ra = $urandom(45); // Seeds the generator.
        rb = $urandom;
        rc = $urandom;
        rs = ra | 32'h8000_0000; // Negative operand for SRA.
        n  = rb[4:0];
        add_row(make_info(exec_pkg::EX_ARITH, exec_pkg::ADD, 6'b000001), ra, rb, 16'h0,
                16'h0, 5'd1, 1'b1, ra + rb, 1'b0, 16'h0, 3);
        add_row(make_info(exec_pkg::EX_ARITH, exec_pkg::ADD, 6'b110001), 32'h100, 32'h0,
                16'hFFFE, 16'h0, 5'd2, 1'b1, 32'h0000_00FE, 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_ARITH, exec_pkg::ADD, 6'b100001), 32'h100, 32'h0,
                16'hFFFE, 16'h0, 5'd3, 1'b1, 32'h0001_00FE, 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_ARITH, exec_pkg::SUB, 6'b000001), ra, rb, 16'h0,
                16'h0, 5'd4, 1'b1, ra - rb, 1'b0, 16'h0, 0);
        // Carry out set, then used by ADC.
        add_row(make_info(exec_pkg::EX_ARITH, exec_pkg::ADD, 6'b000001), 32'hFFFF_FFF0,
                32'h20, 16'h0, 16'h0, 5'd5, 1'b1, 32'h10, 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_ARITH, exec_pkg::ADC, 6'b000001), 32'd5, 32'd6,
                16'h0, 16'h0, 5'd6, 1'b1, 32'd12, 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_ARITH, exec_pkg::ADD, 6'b000001), 32'hFFFF_FFFF,
                32'd1, 16'h0, 16'h0, 5'd7, 1'b1, 32'h0, 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_ARITH, exec_pkg::SBC, 6'b000001), 32'd10, 32'd3,
                16'h0, 16'h0, 5'd8, 1'b1, 32'd7, 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_ARITH, exec_pkg::ADD, 6'b000001), 32'd1, 32'd1,
                16'h0, 16'h0, 5'd9, 1'b1, 32'd2, 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_ARITH, exec_pkg::SBC, 6'b000001), 32'd10, 32'd3,
                16'h0, 16'h0, 5'd10, 1'b1, 32'd6, 1'b0, 16'h0, 0); // Borrow taken.
        add_row(make_info(exec_pkg::EX_SHIFT, exec_pkg::SLL, 6'b000001), ra, rb, 16'h0,
                16'h0, 5'd11, 1'b1, ra << n, 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_SHIFT, exec_pkg::SRL, 6'b000001), ra, rb, 16'h0,
                16'h0, 5'd12, 1'b1, ra >> n, 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_SHIFT, exec_pkg::SRA, 6'b000001), rs, rb, 16'h0,
                16'h0, 5'd13, 1'b1, $signed(rs) >>> n, 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_SHIFT, exec_pkg::ROR, 6'b000001), ra, rb, 16'h0,
                16'h0, 5'd14, 1'b1, rotate_right(ra, n), 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_LOGIC, exec_pkg::AND, 6'b000001), ra, rb, 16'h0,
                16'h0, 5'd15, 1'b1, ra & rb, 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_LOGIC, exec_pkg::OR, 6'b000001), ra, rb, 16'h0,
                16'h0, 5'd16, 1'b1, ra | rb, 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_LOGIC, exec_pkg::XOR, 6'b000000), ra, rb, 16'h0,
                16'h0, 5'd17, 1'b1, ra ^ rb, 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_LOGIC, exec_pkg::NAND, 6'b000001), ra, rb, 16'h0,
                16'h0, 5'd18, 1'b1, ~(ra & rb), 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_LOGIC, exec_pkg::SETH, 6'b000001), ra, rb, 16'hBEEF,
                16'h0, 5'd19, 1'b1, 32'hBEEF_0000, 1'b0, 16'h0, 0);
        // Equal compare, then EQ and NE branches.
        add_row(make_info(exec_pkg::EX_ARITH, exec_pkg::CMP, 6'b000000), 32'h1234,
                32'h1234, 16'h0, 16'h0, 5'd20, 1'b1, 32'h0, 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_NONE, 4'd1, 6'b110100), {28'h0, exec_pkg::CC_EQ},
                32'h0, 16'hFFF0, 16'h0040, 5'd0, 1'b0, 32'h0, 1'b1, 16'h0030, 0);
        add_row(make_info(exec_pkg::EX_NONE, 4'd0, 6'b000100), {28'h0, exec_pkg::CC_NE},
                32'h1234, 16'h0, 16'h0, 5'd0, 1'b0, 32'h0, 1'b0, 16'h1234, 0);
        // Signed overflow sets sign and overflow.
        add_row(make_info(exec_pkg::EX_ARITH, exec_pkg::ADD, 6'b000001), 32'h7FFF_FFFF,
                32'd1, 16'h0, 16'h0, 5'd21, 1'b1, 32'h8000_0000, 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_NONE, 4'd1, 6'b100100), {28'h0, exec_pkg::CC_VS},
                32'h0, 16'h0020, 16'h0100, 5'd0, 1'b0, 32'h0, 1'b1, 16'h0120, 0);
        add_row(make_info(exec_pkg::EX_NONE, 4'd0, 6'b000100), {28'h0, exec_pkg::CC_LT},
                32'hABCD, 16'h0, 16'h0, 5'd0, 1'b0, 32'h0, 1'b0, 16'hABCD, 0);
        add_row(make_info(exec_pkg::EX_NONE, 4'd0, 6'b000100), {28'h0, exec_pkg::CC_GE},
                32'h0F00, 16'h0, 16'h0, 5'd0, 1'b0, 32'h0, 1'b1, 16'h0F00, 0);
        // Store at 0x110, filler, then loads.
        add_row(make_info(exec_pkg::EX_NONE, 4'd1, 6'b001000), 32'h100, rc, 16'h0010,
                16'h0, 5'd0, 1'b0, 32'h0, 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_ARITH, exec_pkg::SUB, 6'b100001), 32'h50, 32'h0,
                16'h0010, 16'h0, 5'd22, 1'b1, 32'h40, 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_NONE, 4'd0, 6'b001001), 32'h100, 32'h0, 16'h0010,
                16'h0, 5'd23, 1'b1, rc, 1'b0, 16'h0, 2);
        add_row(make_info(exec_pkg::EX_NONE, 4'd0, 6'b001001), 32'h200, 32'h0, 16'h0,
                16'h0, 5'd24, 1'b1, 32'h0, 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_NONE, 4'd0, 6'b000010), 32'h0, 32'h0, 16'h0,
                16'h0, 5'd0, 1'b0, 32'h0, 1'b0, 16'h0, 0);
        add_row(make_info(exec_pkg::EX_ARITH, exec_pkg::ADD, 6'b000001), 32'd3, 32'd4,
                16'h0, 16'h0, 5'd25, 1'b1, 32'd7, 1'b0, 16'h0, 0);
    endtask

    task automatic check_value(
        input string       name,
        input logic [31:0] got,
        input logic [31:0] expected,
        input int          row
    );
        assert (got === expected) else begin
            $display("CHECK FAILED %s row %0d: got 0x%h, expected 0x%h",
                     name, row, got, expected);
            $display("=== FAIL ===");
            $fatal(1, "Value mismatch.");
        end
    endtask

    task automatic drive_row(input int i);
        v_i      <= 1'b1;
        d_info_i <= rows[i].d;
        opr0_i   <= rows[i].a;
        opr1_i   <= rows[i].b;
        imm_i    <= rows[i].imm;
        pc_i     <= rows[i].pc;
        wb_r_i   <= rows[i].rd;
    endtask

    // Combinational outputs while the row is presented.
    task automatic check_comb(input int i);
        check_value("branch_o", branch_o, rows[i].br, i);
        check_value("brf_o", brf_o, rows[i].d.brf, i);
        check_value("hlt_o", hlt_o, rows[i].d.hltf, i);
        if (rows[i].d.brf) begin
            check_value("branch_addr_o", branch_addr_o, rows[i].baddr, i);
        end
    endtask

    task automatic check_out(input int i);
        check_value("v_o", v_o, 1'b1, i);
        check_value("wb_o", wb_o, rows[i].d.wrsv, i);
        check_value("wb_r_o", wb_r_o, rows[i].rd, i);
        if (rows[i].chk_res) begin
            check_value("result_o", result_o, rows[i].res, i);
        end
    endtask

    initial begin : watchdog
        int limit;
        wait (table_done === 1'b1);
        limit = 8 + n_rows + total_stall + 20;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles.", limit);
        $display("=== FAIL ===");
        $fatal(1, "Timeout.");
    end

    initial begin
        int s;
        clk         = 1'b0;
        reset       = 1'b0;
        v_i         = 1'b1; // Valid halt and branch during reset.
        stall_i     = 1'b0;
        pc_i        = '0;
        imm_i       = '0;
        opr0_i      = '0; // CC_AL.
        opr1_i      = '0;
        d_info_i    = make_info(exec_pkg::EX_NONE, 4'd0, 6'b000111);
        wb_r_i      = '0;
        n_rows      = 0;
        total_stall = 0;
        table_done  = 1'b0;
        build_table();
        table_done = 1'b1;

        repeat (8) @(posedge clk);
        reset <= 1'b1;
        v_i   <= 1'b0;
        @(negedge clk);
        check_value("v_o", v_o, 1'b0, -1);
        check_value("wb_o", wb_o, 1'b0, -1);
        check_value("branch_o", branch_o, 1'b0, -1);
        check_value("brf_o", brf_o, 1'b0, -1);
        check_value("hlt_o", hlt_o, 1'b0, -1);

        // Row i is presented while row i-1 sits on the outputs.
        for (int i = 0; i <= n_rows; i++) begin
            @(posedge clk);
            if (i < n_rows) begin
                drive_row(i);
            end else begin
                v_i <= 1'b0;
            end
            if (i > 0) begin
                stall_i <= (rows[i-1].stall != 0);
            end
            @(negedge clk);
            if (i < n_rows) begin
                check_comb(i);
            end
            if (i > 0) begin
                check_out(i - 1);
                for (s = 0; s < rows[i-1].stall; s++) begin
                    @(posedge clk);
                    if (s == rows[i-1].stall - 1) begin
                        stall_i <= 1'b0;
                    end
                    @(negedge clk);
                    check_value("stall_o", stall_o, (s < rows[i-1].stall - 1), i - 1);
                    check_out(i - 1); // Held under stall.
                end
            end
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule
